/* verilog/noc_pkg.sv */
/*
 * Shared definitions for one router of a 4x4 mesh NoC.
 * Every packet is a single flit, and the flit keeps its VC from input to output.
 */
package noc_pkg;

    // Mesh geometry, router id = y * mesh_cols + x, y grows southward
    localparam int mesh_cols   = 4;
    localparam int mesh_rows   = 4;
    localparam int num_routers = mesh_cols * mesh_rows;

    // Flit layout: destination id on top, then VC bit, then payload
    localparam int flit_w   = 32;
    localparam int dest_w   = $clog2(num_routers);
    localparam int dest_msb = flit_w - 1;
    localparam int vc_bit   = dest_msb - dest_w;

    // Router ports and virtual channels
    localparam int num_ports = 5;
    localparam int num_vc    = 2;
    localparam int vc_w      = 1;

    // VC buffers and credit counters
    localparam int buffer_depth = 2;
    localparam int ptr_w        = $clog2(buffer_depth);
    // Holds 0..buffer_depth
    localparam int cr_w         = $clog2(buffer_depth) + 1;

    typedef logic [flit_w-1:0] flit_t;

    // One-hot output port request, bit index is a port_e value
    typedef logic [num_ports-1:0] port_mask_t;

    // Values index every port array in the design
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_north = 3'd1,
        port_south = 3'd2,
        port_east  = 3'd3,
        port_west  = 3'd4
    } port_e;

endpackage

/* verilog/vc_buffer.sv */
/*
 * VC FIFOs of one input port, buffer_depth flits each.
 * The sender must hold a credit, a push into a full VC is an error.
 */
`timescale 1ns/100ps

module vc_buffer (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  noc_pkg::flit_t                       in_flit,
    input  logic                                 in_valid,
    input  logic [noc_pkg::num_vc-1:0]           pop,
    output noc_pkg::flit_t [noc_pkg::num_vc-1:0] head_flit,
    output logic [noc_pkg::num_vc-1:0]           head_valid,
    output logic [noc_pkg::num_vc-1:0]           upstr_credit
);

    for (genvar v = 0; v < noc_pkg::num_vc; v++) begin : g_vc
        noc_pkg::flit_t                   mem [noc_pkg::buffer_depth];
        logic [noc_pkg::ptr_w-1:0]        wr_ptr;
        logic [noc_pkg::ptr_w-1:0]        rd_ptr;
        logic [noc_pkg::cr_w-1:0]         count;
        logic                             push;

        // Write goes to the VC named in the flit
        assign push = in_valid &&
            (in_flit[noc_pkg::vc_bit +: noc_pkg::vc_w] == noc_pkg::vc_w'(v));

        // Storage, no reset needed
        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= in_flit;
            end
        end

        // Pointers and occupancy
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    // Wrap at the last entry
                    if (wr_ptr == noc_pkg::ptr_w'(noc_pkg::buffer_depth - 1)) begin
                        wr_ptr <= '0;
                    end else begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
                if (pop[v]) begin
                    if (rd_ptr == noc_pkg::ptr_w'(noc_pkg::buffer_depth - 1)) begin
                        rd_ptr <= '0;
                    end else begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
                if (push && !pop[v]) begin
                    count <= count + 1'b1;
                end else if (!push && pop[v]) begin
                    count <= count - 1'b1;
                end
            end
        end

        // One credit pulse per popped flit, the cycle after the pop
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                upstr_credit[v] <= 1'b0;
            end else begin
                upstr_credit[v] <= pop[v];
            end
        end

        assign head_flit[v]  = mem[rd_ptr];
        assign head_valid[v] = (count != '0);

        // Upstream credit accounting must keep the FIFO from overflowing
        a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
            !(push && count == noc_pkg::cr_w'(noc_pkg::buffer_depth)))
            else $error("vc_buffer: push into full VC %0d", v);

        // The allocator only grants VCs with a registered route
        a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
            !(pop[v] && count == '0))
            else $error("vc_buffer: pop from empty VC %0d", v);
    end

endmodule

/* verilog/route_compute.sv */
/*
 * Registered XY routing of every input VC head, X resolved before Y.
 * The request drops in the cycle of a pop and returns from the next head.
 */
`timescale 1ns/100ps

module route_compute #(
    parameter int router_id = 0
) (
    input  logic                                                         clk,
    input  logic                                                         arst_n,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] head_flit,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]           head_valid,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]           pop,
    output noc_pkg::port_mask_t [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] route_req,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]           route_valid
);

    // Dimension order route of one flit as a one-hot port mask
    function automatic noc_pkg::port_mask_t xy_route(input noc_pkg::flit_t flit);
        int             dst_id;
        noc_pkg::port_e dir;
        dst_id = int'(flit[noc_pkg::dest_msb -: noc_pkg::dest_w]);
        // X first, then Y, equal coordinates eject locally
        if (dst_id % noc_pkg::mesh_cols > router_id % noc_pkg::mesh_cols) begin
            dir = noc_pkg::port_east;
        end else if (dst_id % noc_pkg::mesh_cols < router_id % noc_pkg::mesh_cols) begin
            dir = noc_pkg::port_west;
        end else if (dst_id / noc_pkg::mesh_cols < router_id / noc_pkg::mesh_cols) begin
            dir = noc_pkg::port_north;
        end else if (dst_id / noc_pkg::mesh_cols > router_id / noc_pkg::mesh_cols) begin
            dir = noc_pkg::port_south;
        end else begin
            dir = noc_pkg::port_local;
        end
        return noc_pkg::port_mask_t'(1) << dir;
    endfunction

    // Request register per VC, valid cleared on the pop edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            route_req   <= '0;
            route_valid <= '0;
        end else begin
            for (int p = 0; p < noc_pkg::num_ports; p++) begin
                for (int v = 0; v < noc_pkg::num_vc; v++) begin
                    route_req[p][v]   <= xy_route(head_flit[p][v]);
                    route_valid[p][v] <= head_valid[p][v] && !pop[p][v];
                end
            end
        end
    end

endmodule

/* verilog/credit_tracker.sv */
/*
 * Downstream credit counters for the non-local output VCs.
 * The local output always accepts and has no counter.
 */
`timescale 1ns/100ps

module credit_tracker (
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  logic [noc_pkg::num_ports-1:1][noc_pkg::num_vc-1:0] consume,
    input  logic [noc_pkg::num_ports-1:1][noc_pkg::num_vc-1:0] dwnstr_credit,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] credit_avail
);

    // Local port never runs out
    assign credit_avail[noc_pkg::port_local] = '1;

    for (genvar p = 1; p < noc_pkg::num_ports; p++) begin : g_port
        for (genvar v = 0; v < noc_pkg::num_vc; v++) begin : g_vc
            logic [noc_pkg::cr_w-1:0] cnt;

            // Grant and returned credit in the same cycle cancel out
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    cnt <= noc_pkg::cr_w'(noc_pkg::buffer_depth);
                end else begin
                    case ({consume[p][v], dwnstr_credit[p][v]})
                        2'b10: begin
                            if (cnt != '0) begin
                                cnt <= cnt - 1'b1;
                            end
                        end
                        2'b01: begin
                            // Saturate at the downstream buffer size
                            if (cnt != noc_pkg::cr_w'(noc_pkg::buffer_depth)) begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                        default: begin
                            cnt <= cnt;
                        end
                    endcase
                end
            end

            assign credit_avail[p][v] = (cnt != '0);

            // Allocator must not grant without a credit
            a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
                !(consume[p][v] && !dwnstr_credit[p][v] && cnt == '0))
                else $error("credit_tracker: underflow on port %0d VC %0d", p, v);

            // Downstream router returns no more than it was sent
            a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
                !(dwnstr_credit[p][v] && !consume[p][v] &&
                  cnt == noc_pkg::cr_w'(noc_pkg::buffer_depth)))
                else $error("credit_tracker: overflow on port %0d VC %0d", p, v);
        end
    end

endmodule

/* verilog/switch_allocator.sv */
/*
 * Separable input-first round-robin switch allocator.
 * Combinational grants, only the round-robin pointers are registered.
 */
`timescale 1ns/100ps

module switch_allocator (
    input  logic                                                           clk,
    input  logic                                                           arst_n,
    input  noc_pkg::port_mask_t [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] route_req,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]             route_valid,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]             credit_avail,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]             pop,
    output logic [noc_pkg::num_ports-1:1][noc_pkg::num_vc-1:0]             consume,
    output noc_pkg::port_e [noc_pkg::num_ports-1:0]                        xbar_sel,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::vc_w-1:0]               xbar_vc,
    output logic [noc_pkg::num_ports-1:0]                                  xbar_valid
);

    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]    eligible;
    logic [noc_pkg::num_ports-1:0]                         in_found;
    logic [noc_pkg::num_ports-1:0][noc_pkg::vc_w-1:0]      in_vc;
    logic [noc_pkg::num_ports-1:0][noc_pkg::vc_w-1:0]      in_ptr;
    noc_pkg::port_e [noc_pkg::num_ports-1:0]               out_ptr;
    // Grant matrix indexed [input][output]
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] gnt_in;

    // A VC competes only if its target output VC has a credit
    always_comb begin
        for (int i = 0; i < noc_pkg::num_ports; i++) begin
            for (int v = 0; v < noc_pkg::num_vc; v++) begin
                eligible[i][v] = 1'b0;
                for (int o = 0; o < noc_pkg::num_ports; o++) begin
                    if (route_valid[i][v] && route_req[i][v][o] && credit_avail[o][v]) begin
                        eligible[i][v] = 1'b1;
                    end
                end
            end
        end
    end

    // Input stage, one VC per input port from its pointer onward
    always_comb begin
        int idx;
        for (int i = 0; i < noc_pkg::num_ports; i++) begin
            in_found[i] = 1'b0;
            in_vc[i]    = '0;
            for (int k = 0; k < noc_pkg::num_vc; k++) begin
                idx = (int'(in_ptr[i]) + k) % noc_pkg::num_vc;
                if (!in_found[i] && eligible[i][idx]) begin
                    in_found[i] = 1'b1;
                    in_vc[i]    = noc_pkg::vc_w'(idx);
                end
            end
        end
    end

    // Output stage, one input port per output
    always_comb begin
        int idx;
        gnt_in = '0;
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            xbar_valid[o] = 1'b0;
            xbar_sel[o]   = noc_pkg::port_local;
            for (int k = 0; k < noc_pkg::num_ports; k++) begin
                idx = (int'(out_ptr[o]) + k) % noc_pkg::num_ports;
                if (!xbar_valid[o] && in_found[idx] && route_req[idx][in_vc[idx]][o]) begin
                    xbar_valid[o]  = 1'b1;
                    xbar_sel[o]    = noc_pkg::port_e'(idx);
                    gnt_in[idx][o] = 1'b1;
                end
            end
            // VC travels unchanged with the flit
            xbar_vc[o] = in_vc[xbar_sel[o]];
        end
    end

    // Pops to the buffers, credits taken from the counters
    always_comb begin
        pop     = '0;
        consume = '0;
        for (int i = 0; i < noc_pkg::num_ports; i++) begin
            if (|gnt_in[i]) begin
                pop[i][in_vc[i]] = 1'b1;
            end
        end
        for (int o = 1; o < noc_pkg::num_ports; o++) begin
            if (xbar_valid[o]) begin
                consume[o][xbar_vc[o]] = 1'b1;
            end
        end
    end

    // Pointers move past the winner only after a grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_ptr  <= '0;
            out_ptr <= {noc_pkg::num_ports{noc_pkg::port_local}};
        end else begin
            for (int i = 0; i < noc_pkg::num_ports; i++) begin
                if (|gnt_in[i]) begin
                    in_ptr[i] <= noc_pkg::vc_w'((int'(in_vc[i]) + 1) % noc_pkg::num_vc);
                end
            end
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                if (xbar_valid[o]) begin
                    out_ptr[o] <= noc_pkg::port_e'((int'(xbar_sel[o]) + 1) % noc_pkg::num_ports);
                end
            end
        end
    end

    // Holds only while route_compute keeps every request one-hot
    for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_chk
        a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(gnt_in[i]))
            else $error("switch_allocator: input %0d granted twice", i);
    end

endmodule

/* verilog/crossbar.sv */
/*
 * Registered switch traversal, one selected VC head per output.
 * Samples the head in the same edge that pops it.
 */
`timescale 1ns/100ps

module crossbar (
    input  logic                                                         clk,
    input  logic                                                         arst_n,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] head_flit,
    input  noc_pkg::port_e [noc_pkg::num_ports-1:0]                      xbar_sel,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::vc_w-1:0]             xbar_vc,
    input  logic [noc_pkg::num_ports-1:0]                                xbar_valid,
    output noc_pkg::flit_t [noc_pkg::num_ports-1:0]                      out_flit,
    output logic [noc_pkg::num_ports-1:0]                                out_valid
);

    // Payload path, no reset
    always_ff @(posedge clk) begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            if (xbar_valid[o]) begin
                out_flit[o] <= head_flit[xbar_sel[o]][xbar_vc[o]];
            end
        end
    end

    // Output strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= xbar_valid;
        end
    end

endmodule

/* verilog/router_top.sv */
/*
 * One mesh router with five ports and two VCs per port, XY routing.
 * router_id gives the position, minimum latency is 3 cycles.
 */
`timescale 1ns/100ps

module router_top #(
    parameter int router_id = 0
) (
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0]            in_flit,
    input  logic [noc_pkg::num_ports-1:0]                      in_valid,
    // Credits returned by the neighbours, non-local ports only
    input  logic [noc_pkg::num_ports-1:1][noc_pkg::num_vc-1:0] dwnstr_credit,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] upstr_credit,
    output noc_pkg::flit_t [noc_pkg::num_ports-1:0]            out_flit,
    output logic [noc_pkg::num_ports-1:0]                      out_valid
);

    noc_pkg::flit_t [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]      head_flit;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]                head_valid;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]                pop;
    noc_pkg::port_mask_t [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] route_req;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]                route_valid;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0]                credit_avail;
    logic [noc_pkg::num_ports-1:1][noc_pkg::num_vc-1:0]                consume;
    noc_pkg::port_e [noc_pkg::num_ports-1:0]                           xbar_sel;
    logic [noc_pkg::num_ports-1:0][noc_pkg::vc_w-1:0]                  xbar_vc;
    logic [noc_pkg::num_ports-1:0]                                     xbar_valid;

    // Buffer write, one VC buffer per input port
    for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_in
        vc_buffer i_vc_buffer (
            .clk          (clk),
            .arst_n       (arst_n),
            .in_flit      (in_flit[p]),
            .in_valid     (in_valid[p]),
            .pop          (pop[p]),
            .head_flit    (head_flit[p]),
            .head_valid   (head_valid[p]),
            .upstr_credit (upstr_credit[p])
        );
    end

    // Route compute
    route_compute #(
        .router_id (router_id)
    ) i_route_compute (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_flit   (head_flit),
        .head_valid  (head_valid),
        .pop         (pop),
        .route_req   (route_req),
        .route_valid (route_valid)
    );

    // Output VC credits
    credit_tracker i_credit_tracker (
        .clk           (clk),
        .arst_n        (arst_n),
        .consume       (consume),
        .dwnstr_credit (dwnstr_credit),
        .credit_avail  (credit_avail)
    );

    // Switch allocation
    switch_allocator i_switch_allocator (
        .clk          (clk),
        .arst_n       (arst_n),
        .route_req    (route_req),
        .route_valid  (route_valid),
        .credit_avail (credit_avail),
        .pop          (pop),
        .consume      (consume),
        .xbar_sel     (xbar_sel),
        .xbar_vc      (xbar_vc),
        .xbar_valid   (xbar_valid)
    );

    // Switch traversal
    crossbar i_crossbar (
        .clk        (clk),
        .arst_n     (arst_n),
        .head_flit  (head_flit),
        .xbar_sel   (xbar_sel),
        .xbar_vc    (xbar_vc),
        .xbar_valid (xbar_valid),
        .out_flit   (out_flit),
        .out_valid  (out_valid)
    );

endmodule

/* test/router_tb.sv */
/*
 * Testbench for router_top placed at router 5 (x 1, y 1) of the 4x4 mesh.
 * Payload bits 26..24 carry the source port, so one queue per input VC suffices.
 * Acts as the downstream neighbour on every non-local output.
 */
`timescale 1ns/100ps

module router_tb;

    localparam int router_id = 5;
    // Source port field inside the payload
    localparam int src_msb   = noc_pkg::vc_bit - 1;
    localparam int num_rows  = 23;
    localparam int max_wait  = 500;
    localparam int quiet_len = 10;

    typedef struct packed {
        logic [1:0]     phase;
        noc_pkg::port_e src;
        logic [3:0]     dest;
        logic           vc;
        logic           ret;
    } stim_t;

    // Phase, input port, destination id, VC, downstream credits returned
    stim_t stim [num_rows] = '{
        // Every output direction once
        '{2'd0, noc_pkg::port_local, 4'd5,  1'b0, 1'b1},
        '{2'd0, noc_pkg::port_north, 4'd13, 1'b1, 1'b1},
        '{2'd0, noc_pkg::port_south, 4'd1,  1'b0, 1'b1},
        '{2'd0, noc_pkg::port_west,  4'd6,  1'b1, 1'b1},
        '{2'd0, noc_pkg::port_east,  4'd4,  1'b0, 1'b1},
        '{2'd0, noc_pkg::port_local, 4'd8,  1'b1, 1'b1},
        // Contention on east and west
        '{2'd1, noc_pkg::port_local, 4'd6,  1'b0, 1'b1},
        '{2'd1, noc_pkg::port_north, 4'd7,  1'b0, 1'b1},
        '{2'd1, noc_pkg::port_south, 4'd2,  1'b0, 1'b1},
        '{2'd1, noc_pkg::port_west,  4'd14, 1'b0, 1'b1},
        '{2'd1, noc_pkg::port_east,  4'd0,  1'b1, 1'b1},
        '{2'd1, noc_pkg::port_local, 4'd7,  1'b0, 1'b1},
        '{2'd1, noc_pkg::port_north, 4'd2,  1'b1, 1'b1},
        '{2'd1, noc_pkg::port_south, 4'd6,  1'b0, 1'b1},
        '{2'd1, noc_pkg::port_local, 4'd4,  1'b1, 1'b1},
        // Credits withheld, four flits for east VC 0 plus local traffic
        '{2'd2, noc_pkg::port_local, 4'd6,  1'b0, 1'b0},
        '{2'd2, noc_pkg::port_north, 4'd7,  1'b0, 1'b0},
        '{2'd2, noc_pkg::port_south, 4'd2,  1'b0, 1'b0},
        '{2'd2, noc_pkg::port_west,  4'd14, 1'b0, 1'b0},
        '{2'd2, noc_pkg::port_local, 4'd5,  1'b1, 1'b0},
        '{2'd2, noc_pkg::port_east,  4'd5,  1'b0, 1'b0},
        // Credits back, blocked flits drain
        '{2'd3, noc_pkg::port_north, 4'd9,  1'b1, 1'b1},
        '{2'd3, noc_pkg::port_local, 4'd5,  1'b0, 1'b1}
    };

    logic                                               clk = 1'b0;
    logic                                               arst_n;
    noc_pkg::flit_t [noc_pkg::num_ports-1:0]            in_flit;
    logic [noc_pkg::num_ports-1:0]                      in_valid;
    logic [noc_pkg::num_ports-1:1][noc_pkg::num_vc-1:0] dwnstr_credit = '0;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vc-1:0] upstr_credit;
    noc_pkg::flit_t [noc_pkg::num_ports-1:0]            out_flit;
    logic [noc_pkg::num_ports-1:0]                      out_valid;

    integer seed;
    bit     return_en;
    // Injected flits and returned upstream credits per input VC
    int     inj_cnt  [noc_pkg::num_ports][noc_pkg::num_vc];
    int     cred_cnt [noc_pkg::num_ports][noc_pkg::num_vc];
    // Flits received per output VC and not yet credited back
    int     owed     [noc_pkg::num_ports][noc_pkg::num_vc];
    noc_pkg::flit_t exp_flit_q [noc_pkg::num_ports][noc_pkg::num_vc][$];
    noc_pkg::port_e exp_port_q [noc_pkg::num_ports][noc_pkg::num_vc][$];

    router_top #(
        .router_id (router_id)
    ) i_router_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_flit       (in_flit),
        .in_valid      (in_valid),
        .dwnstr_credit (dwnstr_credit),
        .upstr_credit  (upstr_credit),
        .out_flit      (out_flit),
        .out_valid     (out_valid)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_flit(input noc_pkg::flit_t got, input noc_pkg::flit_t exp);
        if (got !== exp) begin
            report_error($sformatf("flit %h, expected %h", got, exp));
        end
    endtask

    task automatic check_port(input noc_pkg::port_e got, input noc_pkg::port_e exp);
        if (got !== exp) begin
            report_error($sformatf("flit left on %s, expected %s", got.name(), exp.name()));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    // XY rule, x = id mod cols, y = id div cols, y grows southward
    function automatic noc_pkg::port_e xy_port(input int dest);
        int dx;
        int dy;
        dx = dest % noc_pkg::mesh_cols - router_id % noc_pkg::mesh_cols;
        dy = dest / noc_pkg::mesh_cols - router_id / noc_pkg::mesh_cols;
        if (dx > 0) return noc_pkg::port_east;
        if (dx < 0) return noc_pkg::port_west;
        if (dy < 0) return noc_pkg::port_north;
        if (dy > 0) return noc_pkg::port_south;
        return noc_pkg::port_local;
    endfunction

    function automatic int find_row(input int ph, input int p, input int start);
        for (int r = start; r < num_rows; r++) begin
            if (int'(stim[r].phase) == ph && int'(stim[r].src) == p) begin
                return r;
            end
        end
        return -1;
    endfunction

    function automatic int credits_left(input int p, input int v);
        return noc_pkg::buffer_depth - (inj_cnt[p][v] - cred_cnt[p][v]);
    endfunction

    function automatic int pending_flits();
        int n;
        n = 0;
        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            for (int v = 0; v < noc_pkg::num_vc; v++) begin
                n += exp_flit_q[p][v].size();
            end
        end
        return n;
    endfunction

    // All flits out, every output VC credited back by the neighbour model
    function automatic bit drained();
        bit ok;
        ok = (pending_flits() == 0);
        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            for (int v = 0; v < noc_pkg::num_vc; v++) begin
                if (owed[p][v] != 0) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    // Match an output flit against the queue of its source input VC
    task automatic check_output(input int o, input noc_pkg::flit_t f);
        int             s;
        int             v;
        noc_pkg::flit_t exp_f;
        noc_pkg::port_e exp_p;
        s = int'(f[src_msb -: 3]);
        v = int'(f[noc_pkg::vc_bit]);
        if (s >= noc_pkg::num_ports) begin
            report_error($sformatf("flit %h on port %0d has no valid source", f, o));
        end else if (exp_flit_q[s][v].size() == 0) begin
            report_error($sformatf("unexpected flit %h on port %0d", f, o));
        end else begin
            exp_f = exp_flit_q[s][v].pop_front();
            exp_p = exp_port_q[s][v].pop_front();
            check_port(noc_pkg::port_e'(o), exp_p);
            check_flit(f, exp_f);
        end
    endtask

    // Applies one phase of the table, one flit per input port and cycle
    task automatic run_phase(input int ph);
        int             next_row [noc_pkg::num_ports];
        int             r;
        int             v;
        int             cycles;
        bit             busy;
        logic [31:0]    rnd;
        noc_pkg::flit_t f;
        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            next_row[p] = find_row(ph, p, 0);
        end
        for (int i = 0; i < num_rows; i++) begin
            if (int'(stim[i].phase) == ph) begin
                return_en <= stim[i].ret;
            end
        end
        cycles = 0;
        busy   = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = 1'b0;
            for (int p = 0; p < noc_pkg::num_ports; p++) begin
                r = next_row[p];
                v = (r >= 0) ? int'(stim[r].vc) : 0;
                // Inject only while the sender holds a credit
                if (r >= 0 && credits_left(p, v) > 0) begin
                    rnd = $random(seed);
                    f = '0;
                    f[noc_pkg::dest_msb -: noc_pkg::dest_w] = stim[r].dest;
                    f[noc_pkg::vc_bit]                      = stim[r].vc;
                    f[src_msb -: 3]                         = stim[r].src;
                    f[src_msb-3:0]                          = rnd[src_msb-3:0];
                    in_flit[p]  <= f;
                    in_valid[p] <= 1'b1;
                    inj_cnt[p][v]++;
                    exp_flit_q[p][v].push_back(f);
                    exp_port_q[p][v].push_back(xy_port(int'(stim[r].dest)));
                    next_row[p] = find_row(ph, p, r + 1);
                end else begin
                    in_valid[p] <= 1'b0;
                end
                if (next_row[p] >= 0) begin
                    busy = 1'b1;
                end
            end
            cycles++;
            if (cycles > max_wait) begin
                $display("Timeout: no upstream credit to inject phase %0d", ph);
                stop_run();
            end
        end
        @(posedge clk);
        in_valid <= '0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (!drained()) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_wait) begin
                $display("Timeout: flits or credits still outstanding");
                stop_run();
            end
        end
    endtask

    // Until the outputs stay idle for quiet_len cycles
    task automatic wait_quiet();
        int cycles;
        int idle;
        cycles = 0;
        idle   = 0;
        while (idle < quiet_len) begin
            @(posedge clk);
            if (out_valid == '0) begin
                idle++;
            end else begin
                idle = 0;
            end
            cycles++;
            if (cycles > max_wait) begin
                $display("Timeout: outputs never went idle");
                stop_run();
            end
        end
    endtask

    // Scoreboard and upstream credit count
    always @(posedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < noc_pkg::num_ports; p++) begin
                for (int v = 0; v < noc_pkg::num_vc; v++) begin
                    if (upstr_credit[p][v]) begin
                        cred_cnt[p][v] <= cred_cnt[p][v] + 1;
                    end
                end
            end
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                if (out_valid[o]) begin
                    check_output(o, out_flit[o]);
                end
            end
        end
    end

    // Downstream neighbour model, one credit pulse per cycle and output VC
    always @(posedge clk) begin : credit_return
        int sum;
        for (int o = 1; o < noc_pkg::num_ports; o++) begin
            for (int v = 0; v < noc_pkg::num_vc; v++) begin
                sum = owed[o][v];
                if (out_valid[o] && int'(out_flit[o][noc_pkg::vc_bit]) == v) begin
                    sum++;
                end
                if (return_en && sum > 0) begin
                    dwnstr_credit[o][v] <= 1'b1;
                    sum--;
                end else begin
                    dwnstr_credit[o][v] <= 1'b0;
                end
                // Never more flits in the neighbour than its buffer holds
                if (sum > noc_pkg::buffer_depth) begin
                    report_error($sformatf("port %0d VC %0d sent %0d flits without credit",
                        o, v, sum));
                end
                owed[o][v] <= sum;
            end
        end
    end

    initial begin
        seed     = 32'h32c3;
        arst_n   = 1'b0;
        in_flit  = '0;
        in_valid = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_count($countones(out_valid), 0, "out_valid bits after reset");
            check_count($countones(upstr_credit), 0, "upstr_credit bits after reset");
        end

        run_phase(0);
        wait_drained();
        run_phase(1);
        wait_drained();

        // Only buffer_depth flits may pass east VC 0, local traffic passes
        run_phase(2);
        wait_quiet();
        check_count(owed[noc_pkg::port_east][0], noc_pkg::buffer_depth, "east VC 0 flits out");
        check_count(pending_flits(), 2, "flits held for east VC 0");

        run_phase(3);
        wait_drained();
        // Last upstream credit pulses and any stray flit settle here
        wait_quiet();

        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            for (int v = 0; v < noc_pkg::num_vc; v++) begin
                check_count(cred_cnt[p][v], inj_cnt[p][v],
                    $sformatf("upstream credits of port %0d VC %0d", p, v));
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* files.f */
verilog/noc_pkg.sv
verilog/vc_buffer.sv
verilog/route_compute.sv
verilog/credit_tracker.sv
verilog/switch_allocator.sv
verilog/crossbar.sv
verilog/router_top.sv
test/router_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP       := router_tb
FILELIST  := files.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
